// ==== Makefile ====
BIN = obj_dir/Vecc_apb_tb
SRCS = $(shell cat ecc_apb.f)

.PHONY: all run clean

all: run

$(BIN): ecc_apb.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module ecc_apb_tb -f ecc_apb.f

run: $(BIN)
	./$(BIN) | tee sim.log
	grep -q "^Simulation passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== ecc_apb.f ====
verilog/ecc_pkg.sv
verilog/ecc_job_if.sv
verilog/apb_regs.sv
verilog/job_fifo.sv
verilog/ecc_engine.sv
verilog/ecc_apb_top.sv
verif/ecc_apb_props.sv
verif/ecc_apb_tb.sv

// ==== verif/ecc_apb_props.sv ====
module ecc_apb_props (
  input logic clk,
  input logic rst,
  input logic psel,
  input logic penable,
  input logic push,
  input logic full,
  input logic overflow,
  input logic res_done
);

  // ========================================
  // apb protocol
  // ========================================
  penable_needs_psel: assert property (@(posedge clk) disable iff (rst)
    $rose(penable) |-> psel)
    else $error("penable rose while psel was low");

  // ========================================
  // queue and results
  // ========================================
  drop_sets_overflow: assert property (@(posedge clk) disable iff (rst)
    push && full |=> overflow)
    else $error("job pushed into a full queue without setting overflow");

  done_one_cycle: assert property (@(posedge clk) disable iff (rst)
    res_done |=> !res_done)
    else $error("res_done held high for more than one cycle");

endmodule

bind ecc_apb_top ecc_apb_props u_props (
  .clk      (clk),
  .rst      (rst),
  .psel     (psel),
  .penable  (penable),
  .push     (prod_if.push),
  .full     (prod_if.full),
  .overflow (u_regs.overflow_r),
  .res_done (res_done)
);

// ==== verif/ecc_apb_tb.sv ====
module ecc_apb_tb;
  import ecc_pkg::*;

  localparam int DONE_TIMEOUT = 50;
  localparam int OVF_JOBS     = 12;   // producer outruns the engine, queue fills

  logic       clk;
  logic       rst;
  logic       psel;
  logic       penable;
  logic       pwrite;
  amba_addr_t paddr;
  amba_word_t pwdata;
  amba_word_t prdata;
  logic       operation_done;

  logic [31:0] lfsr_state;
  int          checks;
  int          errors;
  int          timeouts;

  ecc_apb_top #(.FIFO_DEPTH(4)) u_dut (
    .clk            (clk),
    .rst            (rst),
    .psel           (psel),
    .penable        (penable),
    .pwrite         (pwrite),
    .paddr          (paddr),
    .pwdata         (pwdata),
    .prdata         (prdata),
    .operation_done (operation_done)
  );

  always #5 clk = ~clk;

  // ========================================
  // random bits and reference model
  // ========================================
  function automatic logic lfsr_bit();
    logic b;
    b = lfsr_state[0];
    lfsr_state = lfsr_state >> 1;
    if (b) lfsr_state ^= 32'h8020_0003;
    return b;
  endfunction

  function automatic amba_word_t rand_word(int nbits);
    amba_word_t r;
    int         i;
    r = '0;
    for (i = 0; i < nbits; i++) r[i] = lfsr_bit();
    return r;
  endfunction

  function automatic int width_bits(cw_width_t wc);
    case (wc)
      cw_8:    return 8;
      cw_16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic amba_word_t data_mask(int w);
    return (32'd1 << (w - $clog2(w) - 1)) - 32'd1;   // 4, 11 or 26 data bits
  endfunction

  function automatic amba_word_t hamming_encode(amba_word_t data, int w);
    amba_word_t cw;
    int         syn;
    int         pos;
    int         di;
    int         k;
    cw  = '0;
    syn = 0;
    di  = 0;
    for (pos = 1; pos < w; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        cw[pos-1] = data[di];
        if (data[di]) syn ^= pos;
        di++;
      end
    end
    // parity bit k equals bit k of the data-only syndrome
    for (k = 0; (1 << k) < w; k++) cw[(1 << k) - 1] = syn[k];
    cw[w-1] = ^cw;
    return cw;
  endfunction

  function automatic amba_word_t hamming_decode(amba_word_t cw, int w, output err_cnt_t errs);
    amba_word_t fix;
    amba_word_t data;
    int         syn;
    int         pos;
    int         di;
    logic       odd;
    syn = 0;
    odd = 1'b0;
    for (pos = 1; pos <= w; pos++) begin
      odd ^= cw[pos-1];
      if (pos < w && cw[pos-1]) syn ^= pos;
    end
    fix = cw;
    if (odd) begin
      errs = 2'd1;
      if (syn != 0) fix[syn-1] = ~fix[syn-1];
    end else if (syn != 0) begin
      errs = 2'd2;
    end else begin
      errs = 2'd0;
    end
    data = '0;
    di   = 0;
    for (pos = 1; pos < w; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        data[di] = fix[pos-1];
        di++;
      end
    end
    return data;
  endfunction

  function automatic amba_word_t flip_mask(int w, int n);
    amba_word_t m;
    int         a;
    int         b;
    m = '0;
    if (n >= 1) begin
      a = int'(rand_word(5)) % w;
      m[a] = 1'b1;
      if (n >= 2) begin
        b = (a + 1 + int'(rand_word(5)) % (w - 1)) % w;   // always differs from a
        m[b] = 1'b1;
      end
    end
    return m;
  endfunction

  // ========================================
  // bus driver and checks
  // ========================================
  task automatic apb_write(input amba_addr_t addr, input amba_word_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b1;
    paddr   = addr;
    pwdata  = data;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;   // returns inside the access cycle
    penable = 1'b0;
  endtask

  task automatic apb_read(input amba_addr_t addr, output amba_word_t data);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = addr;
    @(negedge clk);
    penable = 1'b1;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    @(negedge clk);   // prdata registered at the end of the access cycle
    data = prdata;
  endtask

  task automatic wait_done(input string name, output int cycles);
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (!operation_done && cycles < DONE_TIMEOUT);
    if (!operation_done) begin
      timeouts++;
      $display("%s: no operation_done within %0d cycles", name, DONE_TIMEOUT);
    end
  endtask

  task automatic check_word(input string name, input amba_word_t exp, input amba_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s: expected %h, got %h", name, exp, act);
    end
  endtask

  task automatic check_errors(input string name, input err_cnt_t exp, input err_cnt_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("FAIL %s errors: expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic check_count(input string name, input int exp, input int act);
    checks++;
    if (act != exp) begin
      errors++;
      $display("FAIL %s: expected %0d, got %0d", name, exp, act);
    end
  endtask

  task automatic run_job(input string name, input ecc_op_t op, input cw_width_t wc,
                         input amba_word_t data, input amba_word_t noise,
                         output amba_word_t result, output err_cnt_t errs);
    amba_word_t rd;
    int         cycles;
    apb_write(reg_data_in, data);
    apb_write(reg_cw_width, {30'd0, wc});
    apb_write(reg_noise, noise);
    apb_write(reg_ctrl, {30'd0, op});
    wait_done(name, cycles);
    check_count({name, " latency"}, 6, cycles);
    apb_read(reg_data_out, result);
    apb_read(reg_status, rd);
    errs = rd[1:0];
  endtask

  // ========================================
  // directed tests
  // ========================================
  task automatic test_registers();
    amba_addr_t addrs [6];
    amba_word_t vals [4];
    amba_word_t rd;
    int         i;
    int         cycles;
    addrs = '{reg_ctrl, reg_data_in, reg_cw_width, reg_noise, reg_data_out, reg_status};
    for (i = 0; i < 6; i++) begin
      apb_read(addrs[i], rd);
      check_word($sformatf("reset value at %h", addrs[i]), '0, rd);
    end
    for (i = 0; i < 4; i++) vals[i] = rand_word(32);
    vals[0][1:0] = 2'b00;   // the queued job is an encode
    for (i = 3; i >= 0; i--) apb_write(addrs[i], vals[i]);   // control last
    wait_done("register job", cycles);
    for (i = 0; i < 4; i++) begin
      apb_read(addrs[i], rd);
      check_word($sformatf("readback at %h", addrs[i]), vals[i], rd);
    end
  endtask

  task automatic test_encode();
    amba_word_t data;
    amba_word_t res;
    err_cnt_t   errs;
    cw_width_t  wc;
    string      name;
    int         wi;
    for (wi = 0; wi < 3; wi++) begin
      wc   = cw_width_t'(wi);
      name = $sformatf("encode %0d-bit", width_bits(wc));
      data = rand_word(32);
      run_job(name, op_encode, wc, data, '0, res, errs);
      check_word(name, hamming_encode(data, width_bits(wc)), res);
      check_errors(name, 2'd0, errs);
    end
  endtask

  task automatic test_decode();
    amba_word_t cw;
    amba_word_t res;
    amba_word_t exp;
    err_cnt_t   errs;
    err_cnt_t   exp_errs;
    cw_width_t  wc;
    string      name;
    int         wi;
    int         n;
    for (wi = 0; wi < 3; wi++) begin
      wc = cw_width_t'(wi);
      for (n = 0; n < 3; n++) begin
        name = $sformatf("decode %0d-bit %0d flips", width_bits(wc), n);
        cw   = hamming_encode(rand_word(32), width_bits(wc)) ^ flip_mask(width_bits(wc), n);
        run_job(name, op_decode, wc, cw, '0, res, errs);
        exp  = hamming_decode(cw, width_bits(wc), exp_errs);
        check_word(name, exp, res);
        check_errors(name, exp_errs, errs);
      end
    end
  endtask

  task automatic test_channel();
    amba_word_t data;
    amba_word_t noise;
    amba_word_t res;
    amba_word_t exp;
    err_cnt_t   errs;
    err_cnt_t   model_errs;
    cw_width_t  wc;
    string      name;
    int         w;
    int         wi;
    int         n;
    for (wi = 0; wi < 3; wi++) begin
      wc = cw_width_t'(wi);
      w  = width_bits(wc);
      for (n = 0; n < 3; n++) begin
        name  = $sformatf("channel %0d-bit weight %0d", w, n);
        data  = rand_word(32);
        noise = flip_mask(w, n);
        run_job(name, op_channel, wc, data, noise, res, errs);
        if (n < 2) begin
          exp = data & data_mask(w);   // corrected back to the original
        end else begin
          exp = hamming_decode(hamming_encode(data, w) ^ noise, w, model_errs);
        end
        check_word(name, exp, res);
        check_errors(name, err_cnt_t'(n), errs);
      end
    end
  endtask

  task automatic test_overflow();
    amba_word_t data;
    amba_word_t rd;
    int         done_count;
    int         quiet;
    int         cycles;
    int         i;
    data = rand_word(32);
    apb_write(reg_data_in, data);
    apb_write(reg_cw_width, {30'd0, cw_16});
    done_count = 0;
    quiet      = 0;
    cycles     = 0;
    fork
      begin
        for (i = 0; i < OVF_JOBS; i++) apb_write(reg_ctrl, {30'd0, op_encode});
      end
      begin
        while (quiet < 20 && cycles < 400) begin   // ends once results stop arriving
          @(negedge clk);
          cycles++;
          quiet++;
          if (operation_done) begin
            done_count++;
            quiet = 0;
          end
        end
      end
    join
    if (quiet < 20) begin
      timeouts++;
      $display("overflow: results still arriving after %0d cycles", cycles);
    end
    $display("overflow: %0d of %0d jobs completed", done_count, OVF_JOBS);
    checks++;
    if (done_count < 5 || done_count >= OVF_JOBS) begin
      errors++;
      $display("FAIL overflow results: expected 5 to %0d, got %0d", OVF_JOBS - 1, done_count);
    end
    apb_read(reg_data_out, rd);
    check_word("overflow data out", hamming_encode(data, 16), rd);
    apb_read(reg_status, rd);
    check_word("overflow status", 32'h0000_0004, rd);
  endtask

  // ========================================
  // main sequence
  // ========================================
  initial begin
    clk        = 1'b0;
    rst        = 1'b1;
    psel       = 1'b0;
    penable    = 1'b0;
    pwrite     = 1'b0;
    paddr      = '0;
    pwdata     = '0;
    lfsr_state = 32'hcb36_8617;
    checks     = 0;
    errors     = 0;
    timeouts   = 0;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst = 1'b0;

    test_registers();
    test_encode();
    test_decode();
    test_channel();
    test_overflow();   // overflow is sticky, so it runs last

    $display("ecc_apb_tb: %0d checks, %0d errors, %0d timeouts", checks, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== verilog/apb_regs.sv ====
module apb_regs (
  input  logic               clk,
  input  logic               rst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  ecc_pkg::amba_addr_t paddr,
  input  ecc_pkg::amba_word_t pwdata,
  output ecc_pkg::amba_word_t prdata,
  ecc_job_if.producer        job,
  input  logic               res_done,
  input  ecc_pkg::amba_word_t res_data,
  input  ecc_pkg::err_cnt_t   res_errors
);
  import ecc_pkg::*;

  apb_state_t state;
  apb_state_t state_nxt;

  amba_addr_t addr_q;   // transfer captured at the end of the bus access phase
  amba_word_t wdata_q;
  logic       write_q;

  amba_word_t ctrl_r;
  amba_word_t data_in_r;
  amba_word_t cw_width_r;
  amba_word_t noise_r;
  amba_word_t data_out_r;
  err_cnt_t   errors_r;
  logic       overflow_r;   // sticky, set when a job is dropped
  logic       push_r;

  logic       wr_en;
  logic       rd_en;
  amba_word_t rd_mux;

  // ========================================
  // apb state machine
  // ========================================
  always_comb begin
    state_nxt = state;
    case (state)
      apb_idle:   if (psel && !penable) state_nxt = apb_setup;
      apb_setup: begin
        if (psel && penable) begin
          state_nxt = apb_access;
        end else if (!psel) begin
          state_nxt = apb_idle;   // master abandoned the transfer
        end
      end
      apb_access: state_nxt = apb_idle;
      default:    state_nxt = apb_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= apb_idle;
    end else begin
      state <= state_nxt;
    end
  end

  always_ff @(posedge clk) begin
    if (state == apb_setup && psel && penable) begin
      addr_q  <= paddr;
      wdata_q <= pwdata;
      write_q <= pwrite;
    end
  end

  assign wr_en = (state == apb_access) && write_q;
  assign rd_en = (state == apb_access) && !write_q;

  // ========================================
  // register file
  // ========================================
  always_comb begin
    case (addr_q)
      reg_ctrl:     rd_mux = ctrl_r;
      reg_data_in:  rd_mux = data_in_r;
      reg_cw_width: rd_mux = cw_width_r;
      reg_noise:    rd_mux = noise_r;
      reg_data_out: rd_mux = data_out_r;
      reg_status:   rd_mux = {29'd0, overflow_r, errors_r};
      default:      rd_mux = '0;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ctrl_r     <= '0;
      data_in_r  <= '0;
      cw_width_r <= '0;
      noise_r    <= '0;
      data_out_r <= '0;
      errors_r   <= '0;
      overflow_r <= 1'b0;
      push_r     <= 1'b0;
      prdata     <= '0;
    end else begin
      if (wr_en) begin
        case (addr_q)
          reg_ctrl:     ctrl_r     <= wdata_q;
          reg_data_in:  data_in_r  <= wdata_q;
          reg_cw_width: cw_width_r <= wdata_q;
          reg_noise:    noise_r    <= wdata_q;
          default:      ;                       // read only or unmapped
        endcase
      end
      push_r <= wr_en && (addr_q == reg_ctrl);  // one job per control write
      if (push_r && job.full) overflow_r <= 1'b1;
      if (res_done) begin
        data_out_r <= res_data;
        errors_r   <= res_errors;
      end
      if (rd_en) prdata <= rd_mux;
    end
  end

  // job carries the registers as they stand in the push cycle
  assign job.push  = push_r;
  assign job.op    = ecc_op_t'(ctrl_r[1:0]);
  assign job.width = cw_width_t'(cw_width_r[1:0]);
  assign job.data  = data_in_r;
  assign job.noise = noise_r;

endmodule

// ==== verilog/ecc_apb_top.sv ====
module ecc_apb_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic               clk,
  input  logic               rst,
  input  logic               psel,
  input  logic               penable,
  input  logic               pwrite,
  input  ecc_pkg::amba_addr_t paddr,
  input  ecc_pkg::amba_word_t pwdata,
  output ecc_pkg::amba_word_t prdata,
  output logic               operation_done
);
  import ecc_pkg::*;

  ecc_job_if prod_if ();   // registers to queue
  ecc_job_if cons_if ();   // queue to engine

  logic       res_done;
  amba_word_t res_data;
  err_cnt_t   res_errors;

  apb_regs u_regs (
    .clk        (clk),
    .rst        (rst),
    .psel       (psel),
    .penable    (penable),
    .pwrite     (pwrite),
    .paddr      (paddr),
    .pwdata     (pwdata),
    .prdata     (prdata),
    .job        (prod_if.producer),
    .res_done   (res_done),
    .res_data   (res_data),
    .res_errors (res_errors)
  );

  job_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) u_fifo (
    .clk     (clk),
    .rst     (rst),
    .in_job  (prod_if.fifo_in),
    .out_job (cons_if.fifo_out)
  );

  ecc_engine u_engine (
    .clk        (clk),
    .rst        (rst),
    .job        (cons_if.consumer),
    .res_done   (res_done),
    .res_data   (res_data),
    .res_errors (res_errors)
  );

  assign operation_done = res_done;

endmodule

// ==== verilog/ecc_engine.sv ====
module ecc_engine (
  input  logic               clk,
  input  logic               rst,
  ecc_job_if.consumer        job,
  output logic               res_done,
  output ecc_pkg::amba_word_t res_data,
  output ecc_pkg::err_cnt_t   res_errors
);
  import ecc_pkg::*;

  typedef enum logic [1:0] {eng_idle, eng_load, eng_encode, eng_decode} eng_state_t;

  eng_state_t state;
  ecc_op_t    op_q;
  cw_width_t  width_q;
  amba_word_t data_q;
  amba_word_t noise_q;
  amba_word_t cw_q;      // codeword seen by the decoder

  logic [4:0] syn;
  logic       odd;
  amba_word_t fixed;
  err_cnt_t   dec_err;

  // ========================================
  // hamming helpers
  // ========================================
  function automatic int cw_bits(cw_width_t w);
    case (w)
      cw_8:    return 8;
      cw_16:   return 16;
      default: return 32;
    endcase
  endfunction

  function automatic amba_word_t width_mask(cw_width_t w);
    case (w)
      cw_8:    return 32'h0000_00ff;
      cw_16:   return 32'h0000_ffff;
      default: return 32'hffff_ffff;
    endcase
  endfunction

  function automatic amba_word_t hamming_encode(amba_word_t data, cw_width_t w);
    amba_word_t cw;
    logic       par;
    int         n;
    int         k;
    int         pos;
    int         p;
    cw = '0;
    n  = cw_bits(w);
    k  = 0;
    for (pos = 1; pos < 32; pos++) begin
      if ((pos & (pos - 1)) != 0) begin   // skip parity positions
        if (pos < n) cw[pos-1] = data[k];
        k++;
      end
    end
    for (p = 0; p < 5; p++) begin
      par = 1'b0;
      for (pos = 1; pos < 32; pos++) begin
        if (((pos >> p) & 1) != 0) par ^= cw[pos-1];
      end
      if ((1 << p) < n) cw[(1<<p)-1] = par;
    end
    cw[n-1] = ^cw;   // overall parity in the top bit
    return cw;
  endfunction

  function automatic logic [4:0] syndrome(amba_word_t cw, cw_width_t w);
    logic [4:0] s;
    int         n;
    int         pos;
    s = '0;
    n = cw_bits(w);
    for (pos = 1; pos < 32; pos++) begin
      if (pos < n && cw[pos-1]) s ^= 5'(pos);
    end
    return s;
  endfunction

  function automatic amba_word_t extract_data(amba_word_t cw, cw_width_t w);
    amba_word_t d;
    int         n;
    int         k;
    int         pos;
    d = '0;
    n = cw_bits(w);
    k = 0;
    for (pos = 1; pos < 32; pos++) begin
      if ((pos & (pos - 1)) != 0) begin
        if (pos < n) d[k] = cw[pos-1];
        k++;
      end
    end
    return d;
  endfunction

  // ========================================
  // control and datapath
  // ========================================
  assign job.pop = (state == eng_idle) && !job.empty && !res_done;

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= eng_idle;
      res_done <= 1'b0;
    end else begin
      res_done <= 1'b0;
      case (state)
        eng_idle:   if (job.pop) state <= eng_load;
        eng_load:   state <= eng_encode;
        eng_encode: state <= eng_decode;
        default: begin
          state    <= eng_idle;
          res_done <= 1'b1;
        end
      endcase
    end
  end

  always_comb begin
    syn     = syndrome(cw_q, width_q);
    odd     = ^cw_q;
    fixed   = cw_q;
    dec_err = 2'd0;
    if (odd) begin
      dec_err = 2'd1;
      if (syn != 5'd0) fixed[syn-5'd1] = ~fixed[syn-5'd1];  // zero syndrome means parity bit hit
    end else if (syn != 5'd0) begin
      dec_err = 2'd2;   // detected, left as is
    end
  end

  always_ff @(posedge clk) begin
    if (job.pop) begin
      op_q    <= job.op;
      width_q <= job.width;
      data_q  <= job.data;
      noise_q <= job.noise;
    end
    case (state)
      eng_load: begin
        if (op_q == op_decode) data_q <= data_q & width_mask(width_q);
        noise_q <= noise_q & width_mask(width_q);
      end
      eng_encode: begin
        case (op_q)
          op_encode: cw_q <= hamming_encode(data_q, width_q);
          op_decode: cw_q <= data_q;
          default:   cw_q <= hamming_encode(data_q, width_q) ^ noise_q;  // channel
        endcase
      end
      eng_decode: begin
        if (op_q == op_encode) begin
          res_data   <= cw_q;
          res_errors <= 2'd0;
        end else begin
          res_data   <= extract_data(fixed, width_q);
          res_errors <= dec_err;
        end
      end
      default: ;
    endcase
  end

endmodule

// ==== verilog/ecc_job_if.sv ====
interface ecc_job_if;
  import ecc_pkg::*;

  logic       push;
  logic       full;
  logic       pop;
  logic       empty;
  ecc_op_t    op;
  cw_width_t  width;
  amba_word_t data;
  amba_word_t noise;

  // register block side, pushes jobs
  modport producer (output push, op, width, data, noise, input full);

  // queue write side
  modport fifo_in (input push, op, width, data, noise, output full);

  // queue read side, head entry shown while empty is low
  modport fifo_out (output op, width, data, noise, empty, input pop);

  // engine side, pops jobs
  modport consumer (input op, width, data, noise, empty, output pop);

endinterface

// ==== verilog/ecc_pkg.sv ====
package ecc_pkg;

  // ========================================
  // bus types
  // ========================================
  typedef logic [31:0] amba_word_t;   // apb data word, also codewords and noise
  typedef logic [19:0] amba_addr_t;
  typedef logic [1:0]  err_cnt_t;     // 0, 1 or 2 errors found

  // ========================================
  // job encodings
  // ========================================
  typedef enum logic [1:0] {
    op_encode  = 2'd0,
    op_decode  = 2'd1,
    op_channel = 2'd2                 // code 3 behaves the same
  } ecc_op_t;

  typedef enum logic [1:0] {
    cw_8  = 2'd0,
    cw_16 = 2'd1,
    cw_32 = 2'd2                      // code 3 behaves the same
  } cw_width_t;

  typedef enum logic [1:0] {
    apb_idle,
    apb_setup,
    apb_access
  } apb_state_t;

  // register map
  localparam amba_addr_t reg_ctrl     = 20'h00;
  localparam amba_addr_t reg_data_in  = 20'h04;
  localparam amba_addr_t reg_cw_width = 20'h08;
  localparam amba_addr_t reg_noise    = 20'h0C;
  localparam amba_addr_t reg_data_out = 20'h10;  // read only
  localparam amba_addr_t reg_status   = 20'h14;  // read only

endpackage

// ==== verilog/job_fifo.sv ====
module job_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  logic        clk,
  input  logic        rst,
  ecc_job_if.fifo_in  in_job,
  ecc_job_if.fifo_out out_job
);
  import ecc_pkg::*;

  localparam int AW = $clog2(FIFO_DEPTH);

  ecc_op_t    op_mem    [FIFO_DEPTH];
  cw_width_t  width_mem [FIFO_DEPTH];
  amba_word_t data_mem  [FIFO_DEPTH];
  amba_word_t noise_mem [FIFO_DEPTH];

  logic [AW:0] wr_ptr;   // extra msb tells full from empty
  logic [AW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign in_job.full   = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);
  assign out_job.empty = (wr_ptr == rd_ptr);

  assign do_push = in_job.push && !in_job.full;   // push while full is dropped
  assign do_pop  = out_job.pop && !out_job.empty;

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (do_push) begin
      op_mem[wr_ptr[AW-1:0]]    <= in_job.op;
      width_mem[wr_ptr[AW-1:0]] <= in_job.width;
      data_mem[wr_ptr[AW-1:0]]  <= in_job.data;
      noise_mem[wr_ptr[AW-1:0]] <= in_job.noise;
    end
  end

  // head entry
  assign out_job.op    = op_mem[rd_ptr[AW-1:0]];
  assign out_job.width = width_mem[rd_ptr[AW-1:0]];
  assign out_job.data  = data_mem[rd_ptr[AW-1:0]];
  assign out_job.noise = noise_mem[rd_ptr[AW-1:0]];

endmodule
